// File: hdl/mips_pkg.sv
// mips_lite shared definitions
// word and address types, instruction field enums and ALU operations
package mips_pkg;

   typedef logic [31:0] word_t;
   // bus address counts words, not bytes
   typedef logic [29:0] waddr_t;
   typedef logic [4:0]  reg_idx_t;

   // primary opcode field, bits 31:26
   typedef enum logic [5:0] {
      op_special = 6'h00,
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addiu   = 6'h09,
      op_andi    = 6'h0c,
      op_ori     = 6'h0d,
      op_lui     = 6'h0f,
      op_lw      = 6'h23,
      op_sw      = 6'h2b
   } opcode_e;

   // function field of special opcodes, bits 5:0
   typedef enum logic [5:0] {
      fn_sll     = 6'h00,
      fn_srl     = 6'h02,
      fn_syscall = 6'h0c,
      fn_addu    = 6'h21,
      fn_subu    = 6'h23,
      fn_and     = 6'h24,
      fn_or      = 6'h25,
      fn_xor     = 6'h26,
      fn_nor     = 6'h27,
      fn_slt     = 6'h2a
   } funct_e;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor,
      alu_nor, alu_slt, alu_sll, alu_srl, alu_lui
   } alu_op_e;

   localparam reg_idx_t reg_zero  = 5'd0;
   localparam int       reg_count = 32;

endpackage

// File: hdl/mips_alu.sv
// integer ALU
// arithmetic, logic and shift results, plus rs == rt for branches
module mips_alu (
   input  mips_pkg::word_t   op_a,
   input  mips_pkg::word_t   op_b,
   input  logic [4:0]        shamt,
   input  mips_pkg::alu_op_e alu_op,
   input  logic              alu_use_imm,
   input  mips_pkg::word_t   imm,
   output mips_pkg::word_t   result,
   output logic              zero
);
   import mips_pkg::*;

   word_t src_b;
   logic  less;

   assign src_b = alu_use_imm ? imm : op_b;
   // signed compare for SLT
   assign less  = $signed(op_a) < $signed(src_b);

   always_comb
   begin
      case (alu_op)
         alu_add: result = op_a + src_b;
         alu_sub: result = op_a - src_b;
         alu_and: result = op_a & src_b;
         alu_or:  result = op_a | src_b;
         alu_xor: result = op_a ^ src_b;
         alu_nor: result = ~(op_a | src_b);
         alu_slt: result = {31'b0, less};
         // shifts act on rt by the shamt field
         alu_sll: result = op_b << shamt;
         alu_srl: result = op_b >> shamt;
         alu_lui: result = {imm[15:0], 16'h0};
         default: result = '0;
      endcase
   end

   // always the two registers, never the immediate
   assign zero = (op_a == op_b);

endmodule

// File: hdl/reg_file.sv
// general purpose register file
// 32 words, two asynchronous reads, one clocked write, $0 reads zero
module reg_file (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs,
   input  mips_pkg::reg_idx_t rt,
   input  mips_pkg::reg_idx_t wr_idx,
   input  logic               we,
   input  mips_pkg::word_t    wdata,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);
   import mips_pkg::*;

   word_t regs [reg_count];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 0; i < reg_count; i++)
            regs[i] <= '0;
      end
      else if (we && (wr_idx != reg_zero))
         regs[wr_idx] <= wdata;
   end

   assign rs_data = (rs == reg_zero) ? '0 : regs[rs];
   assign rt_data = (rt == reg_zero) ? '0 : regs[rt];

endmodule

// File: hdl/instr_decoder.sv
// instruction decoder
// splits the instruction word into fields and control bits
module instr_decoder (
   input  mips_pkg::word_t    instr,
   output mips_pkg::reg_idx_t rs,
   output mips_pkg::reg_idx_t rt,
   output mips_pkg::reg_idx_t wr_idx,
   output mips_pkg::word_t    imm,
   output logic [4:0]         shamt,
   output mips_pkg::alu_op_e  alu_op,
   output logic               alu_use_imm,
   output logic               reg_write,
   output logic               is_mem,
   output logic               is_load,
   output logic               is_branch_eq,
   output logic               is_branch_ne,
   output logic               is_jump,
   output logic               is_syscall
);
   import mips_pkg::*;

   opcode_e  opcode;
   funct_e   funct;
   reg_idx_t rd;
   logic     wr_en;
   logic     use_rd;
   logic     zero_ext;

   assign opcode = opcode_e'(instr[31:26]);
   assign funct  = funct_e'(instr[5:0]);
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign shamt  = instr[10:6];

   // ANDI and ORI take the immediate unsigned
   assign imm    = zero_ext ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

   // R-type writes rd, I-type writes rt, never $0
   assign wr_idx    = use_rd ? rd : rt;
   assign reg_write = wr_en & (wr_idx != reg_zero);

   always_comb
   begin
      alu_op       = alu_add;
      alu_use_imm  = 1'b0;
      wr_en        = 1'b0;
      use_rd       = 1'b0;
      zero_ext     = 1'b0;
      is_mem       = 1'b0;
      is_load      = 1'b0;
      is_branch_eq = 1'b0;
      is_branch_ne = 1'b0;
      is_jump      = 1'b0;
      is_syscall   = 1'b0;
      case (opcode)
         op_special:
         begin
            use_rd = 1'b1;
            wr_en  = 1'b1;
            case (funct)
               fn_sll:     alu_op = alu_sll;
               fn_srl:     alu_op = alu_srl;
               fn_addu:    alu_op = alu_add;
               fn_subu:    alu_op = alu_sub;
               fn_and:     alu_op = alu_and;
               fn_or:      alu_op = alu_or;
               fn_xor:     alu_op = alu_xor;
               fn_nor:     alu_op = alu_nor;
               fn_slt:     alu_op = alu_slt;
               fn_syscall:
               begin
                  wr_en      = 1'b0;
                  is_syscall = 1'b1;
               end
               // unknown function, no-op
               default:    wr_en = 1'b0;
            endcase
         end
         op_j:   is_jump      = 1'b1;
         op_beq: is_branch_eq = 1'b1;
         op_bne: is_branch_ne = 1'b1;
         op_addiu:
         begin
            alu_use_imm = 1'b1;
            wr_en       = 1'b1;
         end
         op_andi:
         begin
            alu_op      = alu_and;
            alu_use_imm = 1'b1;
            zero_ext    = 1'b1;
            wr_en       = 1'b1;
         end
         op_ori:
         begin
            alu_op      = alu_or;
            alu_use_imm = 1'b1;
            zero_ext    = 1'b1;
            wr_en       = 1'b1;
         end
         op_lui:
         begin
            alu_op      = alu_lui;
            alu_use_imm = 1'b1;
            wr_en       = 1'b1;
         end
         // address is rs plus signed offset
         op_lw:
         begin
            alu_use_imm = 1'b1;
            wr_en       = 1'b1;
            is_mem      = 1'b1;
            is_load     = 1'b1;
         end
         op_sw:
         begin
            alu_use_imm = 1'b1;
            is_mem      = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// File: hdl/load_store_unit.sv
// load/store unit
// runs one Wishbone word read or write per mem_start
module load_store_unit (
   input  logic             clk,
   input  logic             rst_b,
   input  logic             mem_start,
   input  logic             is_load,
   input  mips_pkg::word_t  addr,
   input  mips_pkg::word_t  store_data,
   input  logic             d_ack,
   input  mips_pkg::word_t  d_dat_r,
   output logic             d_cyc,
   output logic             d_stb,
   output logic             d_we,
   output mips_pkg::waddr_t d_adr,
   output mips_pkg::word_t  d_dat_w,
   output logic             mem_done,
   output mips_pkg::word_t  load_data
);

   // request rises the cycle after mem_start, drops after ack
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         d_cyc <= 1'b0;
         d_we  <= 1'b0;
      end
      else if (mem_start)
      begin
         d_cyc <= 1'b1;
         d_we  <= ~is_load;
      end
      else if (d_cyc && d_ack)
         d_cyc <= 1'b0;
   end

   // byte address down to word address
   always_ff @(posedge clk)
   begin
      if (mem_start)
      begin
         d_adr   <= addr[31:2];
         d_dat_w <= store_data;
      end
   end

   assign d_stb     = d_cyc;
   assign mem_done  = d_cyc & d_ack;
   assign load_data = d_dat_r;

endmodule

// File: hdl/wb_arbiter.sv
// two-master Wishbone classic arbiter
// data master has priority, grant held while its owner keeps cyc high
module wb_arbiter (
   input  logic             clk,
   input  logic             rst_b,
   input  logic             m0_cyc,
   input  logic             m0_stb,
   input  logic             m0_we,
   input  mips_pkg::waddr_t m0_adr,
   input  mips_pkg::word_t  m0_dat_w,
   output logic             m0_ack,
   output mips_pkg::word_t  m0_dat_r,
   input  logic             m1_cyc,
   input  logic             m1_stb,
   input  logic             m1_we,
   input  mips_pkg::waddr_t m1_adr,
   input  mips_pkg::word_t  m1_dat_w,
   output logic             m1_ack,
   output mips_pkg::word_t  m1_dat_r,
   input  mips_pkg::word_t  wb_dat_r,
   input  logic             wb_ack,
   output logic             wb_cyc,
   output logic             wb_stb,
   output logic             wb_we,
   output mips_pkg::waddr_t wb_adr,
   output mips_pkg::word_t  wb_dat_w
);

   // gnt 0 is fetch, 1 is data
   logic gnt;
   logic lock_vld;
   logic lock_gnt;
   logic lock_hold;

   assign lock_hold = lock_vld & (lock_gnt ? m1_cyc : m0_cyc);
   assign gnt       = lock_hold ? lock_gnt : m1_cyc;

   assign wb_cyc   = gnt ? m1_cyc   : m0_cyc;
   assign wb_stb   = gnt ? m1_stb   : m0_stb;
   assign wb_we    = gnt ? m1_we    : m0_we;
   assign wb_adr   = gnt ? m1_adr   : m0_adr;
   assign wb_dat_w = gnt ? m1_dat_w : m0_dat_w;

   // ack only reaches the owner
   assign m0_ack   = wb_ack & ~gnt;
   assign m1_ack   = wb_ack & gnt;
   assign m0_dat_r = wb_dat_r;
   assign m1_dat_r = wb_dat_r;

   // lock ends with the ack that closes the cycle
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         lock_vld <= 1'b0;
         lock_gnt <= 1'b0;
      end
      else
      begin
         lock_vld <= wb_cyc & ~wb_ack;
         lock_gnt <= gnt;
      end
   end

endmodule

// File: hdl/fetch_sequencer.sv
// instruction sequencer
// holds PC and instruction register, runs the fetch bus cycle,
// steps each instruction through fetch, execute and memory
module fetch_sequencer #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic             clk,
   input  logic             rst_b,
   input  logic             f_ack,
   input  mips_pkg::word_t  f_dat_r,
   input  logic             is_mem,
   input  logic             is_load,
   input  logic             is_branch_eq,
   input  logic             is_branch_ne,
   input  logic             is_jump,
   input  logic             is_syscall,
   input  logic             reg_write,
   input  logic             alu_zero,
   input  mips_pkg::word_t  alu_result,
   input  mips_pkg::word_t  imm,
   input  logic             mem_done,
   input  mips_pkg::word_t  load_data,
   output logic             f_cyc,
   output logic             f_stb,
   output mips_pkg::waddr_t f_adr,
   output mips_pkg::word_t  instr,
   output logic             mem_start,
   output logic             rf_we,
   output mips_pkg::word_t  rf_wdata,
   output logic             halted
);
   import mips_pkg::*;

   typedef enum logic [1:0] {st_fetch, st_execute, st_memory, st_halted} state_e;

   state_e state;
   word_t  pc;
   word_t  ir;
   word_t  pc_plus4;
   word_t  branch_target;
   word_t  jump_target;
   word_t  next_pc;
   logic   take_branch;
   logic   fetch_done;

   assign pc_plus4      = pc + 32'd4;
   // offset counts words
   assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
   assign jump_target   = {pc_plus4[31:28], ir[25:0], 2'b00};
   // alu_zero compares rs with rt
   assign take_branch   = (is_branch_eq & alu_zero) | (is_branch_ne & ~alu_zero);

   always_comb
   begin
      if (is_jump)
         next_pc = jump_target;
      else if (take_branch)
         next_pc = branch_target;
      else
         next_pc = pc_plus4;
   end

   assign fetch_done = f_cyc & f_ack;
   assign f_stb      = f_cyc;
   assign f_adr      = pc[31:2];
   assign instr      = ir;
   assign halted     = (state == st_halted);

   // one-cycle kick to the load/store unit
   assign mem_start = (state == st_execute) & is_mem;

   // ALU ops write at end of execute, LW writes on its data ack
   assign rf_we    = ((state == st_execute) & reg_write & ~is_mem) |
                     ((state == st_memory) & reg_write & is_load & mem_done);
   assign rf_wdata = (state == st_memory) ? load_data : alu_result;

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         state <= st_fetch;
         pc    <= text_start;
         f_cyc <= 1'b0;
      end
      else
      begin
         case (state)
            st_fetch:
            begin
               // raise request out of reset, drop it after ack
               if (fetch_done)
               begin
                  f_cyc <= 1'b0;
                  state <= st_execute;
               end
               else
                  f_cyc <= 1'b1;
            end
            st_execute:
            begin
               if (is_syscall)
                  state <= st_halted;
               else if (is_mem)
                  state <= st_memory;
               else
               begin
                  pc    <= next_pc;
                  f_cyc <= 1'b1;
                  state <= st_fetch;
               end
            end
            st_memory:
            begin
               if (mem_done)
               begin
                  pc    <= next_pc;
                  f_cyc <= 1'b1;
                  state <= st_fetch;
               end
            end
            st_halted:
               state <= st_halted;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_done)
         ir <= f_dat_r;
   end

endmodule

// File: hdl/mips_core_top.sv
// mips_lite core top level
// joins sequencer, decoder, register file, ALU and load/store unit,
// and puts both bus masters on one Wishbone classic bus
module mips_core_top #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic             clk,
   input  logic             rst_b,
   input  mips_pkg::word_t  wb_dat_r,
   input  logic             wb_ack,
   output logic             wb_cyc,
   output logic             wb_stb,
   output logic             wb_we,
   output mips_pkg::waddr_t wb_adr,
   output mips_pkg::word_t  wb_dat_w,
   output logic             halted
);
   import mips_pkg::*;

   // fetch master, bus side
   logic     f_cyc;
   logic     f_stb;
   logic     f_ack;
   waddr_t   f_adr;
   word_t    f_dat_r;
   // data master, bus side
   logic     d_cyc;
   logic     d_stb;
   logic     d_we;
   logic     d_ack;
   waddr_t   d_adr;
   word_t    d_dat_w;
   word_t    d_dat_r;
   // decoded instruction
   word_t    instr;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t wr_idx;
   word_t    imm;
   logic [4:0] shamt;
   alu_op_e  alu_op;
   logic     alu_use_imm;
   logic     reg_write;
   logic     is_mem;
   logic     is_load;
   logic     is_branch_eq;
   logic     is_branch_ne;
   logic     is_jump;
   logic     is_syscall;
   // datapath
   word_t    rs_data;
   word_t    rt_data;
   word_t    alu_result;
   logic     alu_zero;
   logic     rf_we;
   word_t    rf_wdata;
   logic     mem_start;
   logic     mem_done;
   word_t    load_data;

   fetch_sequencer #(.text_start(text_start)) u_seq (
      .clk(clk), .rst_b(rst_b),
      .f_ack(f_ack), .f_dat_r(f_dat_r),
      .is_mem(is_mem), .is_load(is_load),
      .is_branch_eq(is_branch_eq), .is_branch_ne(is_branch_ne),
      .is_jump(is_jump), .is_syscall(is_syscall), .reg_write(reg_write),
      .alu_zero(alu_zero), .alu_result(alu_result), .imm(imm),
      .mem_done(mem_done), .load_data(load_data),
      .f_cyc(f_cyc), .f_stb(f_stb), .f_adr(f_adr), .instr(instr),
      .mem_start(mem_start), .rf_we(rf_we), .rf_wdata(rf_wdata), .halted(halted)
   );

   instr_decoder u_dec (
      .instr(instr), .rs(rs), .rt(rt), .wr_idx(wr_idx), .imm(imm), .shamt(shamt),
      .alu_op(alu_op), .alu_use_imm(alu_use_imm), .reg_write(reg_write),
      .is_mem(is_mem), .is_load(is_load), .is_branch_eq(is_branch_eq),
      .is_branch_ne(is_branch_ne), .is_jump(is_jump), .is_syscall(is_syscall)
   );

   reg_file u_rf (
      .clk(clk), .rst_b(rst_b), .rs(rs), .rt(rt), .wr_idx(wr_idx),
      .we(rf_we), .wdata(rf_wdata), .rs_data(rs_data), .rt_data(rt_data)
   );

   mips_alu u_alu (
      .op_a(rs_data), .op_b(rt_data), .shamt(shamt), .alu_op(alu_op),
      .alu_use_imm(alu_use_imm), .imm(imm), .result(alu_result), .zero(alu_zero)
   );

   // effective address is the ALU sum, store data is rt
   load_store_unit u_lsu (
      .clk(clk), .rst_b(rst_b), .mem_start(mem_start), .is_load(is_load),
      .addr(alu_result), .store_data(rt_data), .d_ack(d_ack), .d_dat_r(d_dat_r),
      .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we), .d_adr(d_adr), .d_dat_w(d_dat_w),
      .mem_done(mem_done), .load_data(load_data)
   );

   // fetch never writes, so its we and write data are tied off
   wb_arbiter u_arb (
      .clk(clk), .rst_b(rst_b),
      .m0_cyc(f_cyc), .m0_stb(f_stb), .m0_we(1'b0), .m0_adr(f_adr), .m0_dat_w('0),
      .m0_ack(f_ack), .m0_dat_r(f_dat_r),
      .m1_cyc(d_cyc), .m1_stb(d_stb), .m1_we(d_we), .m1_adr(d_adr), .m1_dat_w(d_dat_w),
      .m1_ack(d_ack), .m1_dat_r(d_dat_r),
      .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w)
   );

endmodule

// File: verif/wb_bus_checker.sv
// Wishbone protocol and halt checks for the mips_lite core
// bound into the core top level, watches the shared bus and both masters
module wb_bus_checker #(
   parameter mips_pkg::waddr_t skip_a = 30'd0,
   parameter mips_pkg::waddr_t skip_b = 30'd0
) (
   input logic             clk,
   input logic             rst_b,
   input logic             wb_cyc,
   input logic             wb_stb,
   input logic             wb_we,
   input logic             wb_ack,
   input mips_pkg::waddr_t wb_adr,
   input mips_pkg::word_t  wb_dat_w,
   input logic             f_cyc,
   input logic             f_ack,
   input logic             d_cyc,
   input logic             d_ack,
   input logic             halted
);
   timeunit 1ns;
   timeprecision 100ps;

   // set by any failing assertion, the testbench watches it
   logic err_seen = 1'b0;

   // quiet bus and no halt while reset is held
   a_reset_idle: assert property (@(negedge clk) !rst_b |-> !wb_cyc && !halted)
      else
      begin
         err_seen = 1'b1;
         $error("bus active or halted during reset");
      end

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_b) wb_stb |-> wb_cyc)
      else
      begin
         err_seen = 1'b1;
         $error("stb high without cyc");
      end

   // request fields frozen until the slave acks
   a_req_stable: assert property (@(posedge clk) disable iff (!rst_b)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
      else
      begin
         err_seen = 1'b1;
         $error("request changed or dropped while waiting for ack");
      end

   // each master ends its cycle right after its ack
   a_fetch_end: assert property (@(posedge clk) disable iff (!rst_b) f_cyc && f_ack |=> !f_cyc)
      else
      begin
         err_seen = 1'b1;
         $error("fetch cycle held past its ack");
      end

   a_data_end: assert property (@(posedge clk) disable iff (!rst_b) d_cyc && d_ack |=> !d_cyc)
      else
      begin
         err_seen = 1'b1;
         $error("data cycle held past its ack");
      end

   // words behind a taken branch or jump are never read
   a_no_skip: assert property (@(posedge clk) disable iff (!rst_b)
      wb_cyc && !wb_we |-> wb_adr != skip_a && wb_adr != skip_b)
      else
      begin
         err_seen = 1'b1;
         $error("read of a word that control flow should skip");
      end

   a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_b) halted |-> !wb_cyc)
      else
      begin
         err_seen = 1'b1;
         $error("bus cycle after halt");
      end

endmodule

// File: verif/mips_tb.sv
// testbench for the mips_lite core
// builds a hand-encoded program, answers the bus with random wait states
// and checks every store the core makes
module mips_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import mips_pkg::*;

   localparam word_t prog_start = 32'h0000_0000;
   // words that a taken BEQ and a J jump over
   localparam int skip_a = 33;
   localparam int skip_b = 40;

   logic   clk;
   logic   rst_b;
   word_t  wb_dat_r;
   logic   wb_ack;
   logic   wb_cyc;
   logic   wb_stb;
   logic   wb_we;
   waddr_t wb_adr;
   word_t  wb_dat_w;
   logic   halted;

   word_t  mem [256];
   word_t  exp_val [256];
   bit     exp_set [256];
   int     stores_expected;
   int     stores_seen;
   int     n;
   int     slot;
   int     wait_left;
   bit     busy;
   logic [5:0] alu_fn [9] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
                              fn_nor, fn_slt, fn_sll, fn_srl};

   mips_core_top #(.text_start(prog_start)) uut (
      .clk(clk), .rst_b(rst_b), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .halted(halted)
   );

   // skip addresses match skip_a and skip_b
   bind mips_core_top wb_bus_checker #(.skip_a(30'd33), .skip_b(30'd40)) chk (
      .clk(clk), .rst_b(rst_b), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .f_cyc(f_cyc),
      .f_ack(f_ack), .d_cyc(d_cyc), .d_ack(d_ack), .halted(halted)
   );

   always #4 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   function automatic word_t rtype_word(input logic [5:0] fn, input int rs, input int rt,
                                        input int rd, input int sa);
      return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
   endfunction

   function automatic word_t itype_word(input logic [5:0] op, input int rs, input int rt,
                                        input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic word_t sext16(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   // expected R-type results by the MIPS rules, shifts act on rt
   function automatic word_t alu_ref(input logic [5:0] fn, input word_t a, input word_t b,
                                     input logic [4:0] sa);
      case (fn)
         fn_addu: return a + b;
         fn_subu: return a - b;
         fn_and:  return a & b;
         fn_or:   return a | b;
         fn_xor:  return a ^ b;
         fn_nor:  return ~(a | b);
         fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         fn_sll:  return b << sa;
         fn_srl:  return b >> sa;
         default: return 32'h0;
      endcase
   endfunction

   task automatic emit(input word_t w);
      mem[n] = w;
      n++;
   endtask

   task automatic expect_word(input int idx, input word_t val);
      exp_val[idx] = val;
      exp_set[idx] = 1'b1;
      stores_expected++;
   endtask

   // result words start at byte 0x200, word 128
   task automatic store_and_expect(input int rt, input word_t val);
      emit(itype_word(op_sw, 0, rt, 16'(32'h200 + 4 * slot)));
      expect_word(128 + slot, val);
      slot++;
   endtask

   // a store that must never run, it would hit word 255
   task automatic emit_skipped(input int idx);
      assert (n == idx)
         emit(itype_word(op_sw, 0, 1, 16'h03fc));
      else
         abort_run("program layout does not match the skipped words");
   endtask

   task automatic build_program();
      logic [15:0] i1;
      logic [15:0] i2;
      logic [15:0] i3;
      logic [15:0] i4;
      logic [15:0] i5;
      logic [15:0] sig;
      logic [4:0]  sa;
      word_t       r1;
      word_t       r3;
      i1 = 16'($urandom);
      i2 = 16'($urandom);
      i3 = 16'($urandom);
      i4 = 16'($urandom);
      i5 = 16'($urandom);
      r1 = sext16(i1);
      r3 = {i3, i4};
      for (int i = 0; i < 256; i++)
         mem[i] = {24'hbad000, 8'(i)};
      n    = 0;
      slot = 0;
      emit(itype_word(op_addiu, 0, 1, i1));
      emit(itype_word(op_ori, 0, 2, i2));
      emit(itype_word(op_lui, 0, 3, i3));
      emit(itype_word(op_ori, 3, 3, i4));
      // each R-type result goes to its own word
      for (int k = 0; k < 9; k++)
      begin
         sa = 5'($urandom);
         if (alu_fn[k] == fn_sll || alu_fn[k] == fn_srl)
            emit(rtype_word(alu_fn[k], 0, 3, 4 + k, sa));
         else
            emit(rtype_word(alu_fn[k], 1, 3, 4 + k, 0));
         store_and_expect(4 + k, alu_ref(alu_fn[k], r1, r3, sa));
      end
      // ANDI takes its immediate zero extended
      emit(itype_word(op_andi, 3, 13, i5));
      store_and_expect(13, r3 & {16'h0, i5});
      // write to $0 is lost, $0 still reads zero
      emit(rtype_word(fn_addu, 1, 3, 0, 0));
      store_and_expect(0, 32'h0);
      store_and_expect(1, r1);
      store_and_expect(2, {16'h0, i2});
      store_and_expect(3, r3);
      // LW from 0x100 + 0x200, SW back to 0x100 - 0x40, word 48
      mem[192] = $urandom;
      emit(itype_word(op_addiu, 0, 15, 16'h0100));
      emit(itype_word(op_lw, 15, 14, 16'h0200));
      emit(itype_word(op_sw, 15, 14, 16'hffc0));
      expect_word(48, mem[192]);
      // taken BEQ hops over one word
      emit(itype_word(op_beq, 1, 1, 16'd1));
      emit_skipped(skip_a);
      sig = 16'($urandom);
      emit(itype_word(op_addiu, 0, 16, sig));
      store_and_expect(16, sext16(sig));
      // BNE on equal registers falls through to its signature
      emit(itype_word(op_bne, 1, 1, 16'd2));
      sig = 16'($urandom);
      emit(itype_word(op_addiu, 0, 17, sig));
      store_and_expect(17, sext16(sig));
      // J takes a word target
      emit({op_j, 26'(n + 2)});
      emit_skipped(skip_b);
      sig = 16'($urandom);
      emit(itype_word(op_addiu, 0, 18, sig));
      store_and_expect(18, sext16(sig));
      emit(rtype_word(fn_syscall, 0, 0, 0, 0));
   endtask

   // writes must land on expected words with expected data
   task automatic check_write(input int idx, input word_t data);
      assert (exp_set[idx])
      begin
         assert (data === exp_val[idx])
         begin
            mem[idx] = data;
            stores_seen++;
         end
         else
            abort_run($sformatf("FAILED at %0t ns: word %0d expected %h got %h",
                                $time, idx, exp_val[idx], data));
      end
      else
         abort_run($sformatf("store to word %0d, which no instruction should write", idx));
   endtask

   // memory model, 0 to 3 wait states, ack lasts one cycle
   always @(posedge clk)
   begin
      #1;
      if (wb_ack)
         wb_ack = 1'b0;
      else if (rst_b && wb_cyc && wb_stb)
      begin
         if (!busy)
         begin
            busy      = 1'b1;
            wait_left = $urandom % 4;
         end
         if (wait_left > 0)
            wait_left--;
         else
         begin
            busy   = 1'b0;
            wb_ack = 1'b1;
            if (wb_we)
               check_write(int'(wb_adr[7:0]), wb_dat_w);
            else
               wb_dat_r = mem[wb_adr[7:0]];
         end
      end
   end

   always @(negedge clk)
   begin
      if (uut.chk.err_seen)
         abort_run("a bus protocol assertion failed");
   end

   // first bus cycle reads the reset PC
   initial
   begin
      wait (rst_b === 1'b1);
      do
         @(negedge clk);
      while (wb_cyc !== 1'b1);
      assert (!wb_we && wb_adr == prog_start[31:2])
      else
         abort_run("first bus cycle is not a fetch of the reset PC");
   end

   // limit is words times 11 cycles worst case, doubled
   initial
   begin
      #1;
      #(n * 11 * 2 * 8 + 16);
      abort_run("watchdog expired before the core halted");
   end

   initial
   begin
      void'($urandom(32'h1876_268a));
      clk      = 1'b0;
      rst_b    = 1'b0;
      wb_ack   = 1'b0;
      wb_dat_r = '0;
      busy     = 1'b0;
      build_program();
      repeat (2) @(posedge clk);
      #1 rst_b = 1'b1;
      wait (halted === 1'b1);
      // a few edges with halt high so the quiet-bus check sees it
      repeat (4) @(posedge clk);
      @(negedge clk);
      if (stores_seen == stores_expected && !uut.chk.err_seen)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
         abort_run($sformatf("core halted after %0d of %0d expected stores",
                             stores_seen, stores_expected));
   end

endmodule

// File: mips_lite.f
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/load_store_unit.sv
hdl/wb_arbiter.sv
hdl/fetch_sequencer.sv
hdl/mips_core_top.sv
verif/wb_bus_checker.sv
verif/mips_tb.sv

// File: Bender.yml
package:
  name: mips_lite

sources:
  - hdl/mips_pkg.sv
  - hdl/mips_alu.sv
  - hdl/reg_file.sv
  - hdl/instr_decoder.sv
  - hdl/load_store_unit.sv
  - hdl/wb_arbiter.sv
  - hdl/fetch_sequencer.sv
  - hdl/mips_core_top.sv
  - target: simulation
    files:
      - verif/wb_bus_checker.sv
      - verif/mips_tb.sv
